//--- files.f
+incdir+include
logic/controlPkg.sv
logic/instrDecoder.sv
logic/cycleSequencer.sv
logic/controlWordGen.sv
logic/controlUnit.sv
tests/controlUnit_assert.sv
tests/controlUnitTb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and pass only if the pass line shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f files.f \
	--top-module controlUnitTb -o controlUnitSim \
	&& ./obj_dir/controlUnitSim +verilator+error+limit+1000 | tee /dev/stderr \
	| grep -x '>>> PASS' > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- tests/controlUnitTb.sv
// drives one instruction per fetch and checks every cycle on the falling edge; stops on a fetch timeout
`include "control_defs.svh"

module controlUnitTb import controlPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		opcode_t op;
		funct_t  fn;
		logic    ovf;
		logic    eq;
	} instrRec_t;

	logic      clock = 1'b0;
	logic      rstN;
	opcode_t   opcode;
	funct_t    funct;
	logic      overflow;
	logic      equal;
	ctrlWord_t ctrl;

	// stimulus side
	integer    seed;
	instrRec_t curInstr = '0;        // instruction held in the IR
	string     curName = "idle";
	int        issuedCount = 0;
	logic      timedOut = 1'b0;

	// checker side
	int        cycleIdx = 0;         // 0 is fetch
	int        closedCount = 0;
	int        testCount = 0;
	int        failedTests = 0;
	int        testErrors = 0;
	int        errorCount = 0;
	int        checkCount = 0;
	logic      inReset = 1'b1;

	always #10 clock = ~clock;

	controlUnit controlUnit_inst (
		.clock    (clock),
		.rstN     (rstN),
		.opcode   (opcode),
		.funct    (funct),
		.overflow (overflow),
		.equal    (equal),
		.ctrl     (ctrl)
	);

	function automatic instrClass_t refClass(input instrRec_t ins);
		instrClass_t c;
		c = classNone;
		case (ins.op)
			`OP_RTYPE: begin
				case (ins.fn)
					`FN_ADD: c = classAdd;
					`FN_SUB: c = classSub;
					`FN_AND: c = classAnd;
					`FN_SLT: c = classSlt;
					`FN_JR: c = classJr;
					default: c = classNone;
				endcase
			end
			`OP_ADDI: c = classAddi;
			`OP_ADDIU: c = classAddiu;
			`OP_SLTI: c = classSlti;
			`OP_LW: c = classLw;
			`OP_SW: c = classSw;
			`OP_BEQ: c = classBeq;
			`OP_BNE: c = classBne;
			`OP_J: c = classJ;
			default: c = classNone;
		endcase
		return c;
	endfunction

	function automatic int expectedLength(input instrRec_t ins);
		case (refClass(ins))
			classLw: return 5;
			classSw, classAdd, classSub, classAnd, classAddi, classAddiu: return 4;
			default: return 3;
		endcase
	endfunction

	function automatic ctrlWord_t expectedCtrl(input instrRec_t ins, input int idx);
		ctrlWord_t   w;
		instrClass_t c;
		int          len;
		w = '0;   // every write low, selectors at their first value
		c = refClass(ins);
		len = expectedLength(ins);
		if (idx == 0 || idx >= len) begin
			w.irWrite = 1'b1;
			w.pcWrite = 1'b1;
			w.aluSrcB = srcFour;
			w.aluOp = aluAdd;
		end else if (idx == 1) begin
			w.abLoad = 1'b1;
			w.aluSrcB = srcBranchOffset;
			w.aluOp = aluAdd;
			w.aluOutWrite = 1'b1;
		end else if (idx == 2) begin
			case (c)
				classAdd, classSub, classAnd: begin
					w.aluSrcA = srcRegA;
					w.aluOutWrite = 1'b1;
					if (c == classAdd) begin
						w.aluOp = aluAdd;
					end else if (c == classSub) begin
						w.aluOp = aluSub;
					end else begin
						w.aluOp = aluAnd;
					end
				end
				classAddi, classAddiu, classLw, classSw: begin
					w.aluSrcA = srcRegA;
					w.aluSrcB = srcSignImm;
					w.aluOp = aluAdd;
					w.aluOutWrite = 1'b1;
				end
				classSlt, classSlti: begin
					w.aluSrcA = srcRegA;
					w.aluOp = aluSlt;
					w.regWrite = 1'b1;
					w.regData = dataLessThan;
					if (c == classSlti) begin
						w.aluSrcB = srcSignImm;
						w.regDst = dstRt;
					end
				end
				classBeq, classBne: begin
					w.aluSrcA = srcRegA;
					w.aluOp = aluSub;
					w.pcSource = pcAluOut;
					w.pcWrite = (c == classBeq) ? ins.eq : !ins.eq;   // taken branch only
				end
				classJ: begin
					w.pcSource = pcJumpTarget;
					w.pcWrite = 1'b1;
				end
				classJr: begin
					w.pcSource = pcRegA;
					w.pcWrite = 1'b1;
				end
				default: ;
			endcase
		end else if (idx == 3 && (c == classLw || c == classSw)) begin
			w.memAddrSel = addrAluOut;
			w.mdrWrite = (c == classLw);
			w.memWrite = (c == classSw);
		end else if (ins.ovf && (c == classAdd || c == classSub || c == classAddi)) begin
			w.epcWrite = 1'b1;   // overflow trap
			w.pcSource = pcExceptionVector;
			w.pcWrite = 1'b1;
		end else begin
			w.regWrite = 1'b1;
			if (c == classAddi || c == classAddiu || c == classLw) begin
				w.regDst = dstRt;
			end
			if (c == classLw) begin
				w.regData = dataMdr;
			end
		end
		return w;
	endfunction

	function automatic ctrlWord_t resetWord();
		ctrlWord_t w;
		w = '0;   // fetch selectors, writes masked
		w.aluSrcB = srcFour;
		w.aluOp = aluAdd;
		return w;
	endfunction

	function automatic logic randomBit();
		int r;
		r = $random(seed);
		return r[0];
	endfunction

	task automatic checkCtrlWord(input ctrlWord_t got, input ctrlWord_t exp, input string what);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			testErrors++;
			$display("FAIL %0d ns: %s, ctrl %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkLength(input int got, input int exp, input string what);
		checkCount++;
		if (got != exp) begin
			errorCount++;
			testErrors++;
			$display("FAIL %0d ns: %s ran %0d cycles, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic reportTest(input string what);
		testCount++;
		if (testErrors == 0) begin
			$display("test %0d %s: ok", testCount, what);
		end else begin
			failedTests++;
			$display("test %0d %s: %0d mismatches", testCount, what, testErrors);
		end
		testErrors = 0;
	endtask

	// compare every cycle where ctrl is settled
	always @(negedge clock) begin
		if (!rstN) begin
			checkCtrlWord(ctrl, resetWord(), "reset");
		end else begin
			if (ctrl.irWrite) begin
				if (issuedCount > closedCount) begin
					checkLength(cycleIdx, expectedLength(curInstr), curName);
					reportTest(curName);
					closedCount++;
				end
				cycleIdx = 0;
			end
			checkCtrlWord(ctrl, expectedCtrl(curInstr, cycleIdx),
				$sformatf("%s cycle %0d", curName, cycleIdx));
			cycleIdx++;
			if (inReset) begin
				reportTest("reset and first fetch");
				inReset = 1'b0;
			end
		end
	end

	task automatic waitFetch(input string forWhat);
		int waited;
		waited = 0;
		@(negedge clock);
		while (!ctrl.irWrite && waited < 10) begin
			@(negedge clock);
			waited++;
		end
		if (!ctrl.irWrite) begin
			$display("timeout: no instruction fetch within 10 cycles before %s", forWhat);
			timedOut = 1'b1;
		end
	endtask

	// new instruction goes in on the edge that ends fetch
	task automatic issue(input opcode_t op, input funct_t fn, input logic ovf, input logic eq,
			input string label);
		if (!timedOut) begin
			waitFetch(label);
		end
		if (!timedOut) begin
			@(posedge clock);
			opcode <= op;
			funct <= fn;
			overflow <= ovf;
			equal <= eq;
			curInstr = '{op: op, fn: fn, ovf: ovf, eq: eq};
			curName = $sformatf("%s ovf=%0b eq=%0b", label, ovf, eq);
			issuedCount++;
		end
	endtask

	task automatic issueUnkept(input int count);
		instrRec_t r;
		int        made;
		int        tries;
		int        raw;
		made = 0;
		tries = 0;
		while (made < count && tries < 1000) begin
			raw = $random(seed);
			r = '{op: raw[5:0], fn: raw[13:8], ovf: raw[16], eq: raw[17]};
			if (made % 2 == 0) begin
				r.op = `OP_RTYPE;   // exercise unkept funct values too
			end
			if (refClass(r) == classNone) begin
				issue(r.op, r.fn, r.ovf, r.eq, $sformatf("unkept op=%0d fn=%0d", r.op, r.fn));
				made++;
			end
			tries++;
		end
	endtask

	initial begin
		int   rep;
		logic assertFailed;
		seed = 32'ha233_73f2;
		rstN = 1'b0;
		opcode = '0;
		funct = '0;
		overflow = 1'b0;
		equal = 1'b0;
		repeat (4) @(posedge clock);
		rstN <= 1'b1;

		for (rep = 0; rep < 2; rep++) begin
			issue(`OP_RTYPE, `FN_ADD, randomBit(), randomBit(), "ADD");
			issue(`OP_RTYPE, `FN_SUB, randomBit(), randomBit(), "SUB");
			issue(`OP_RTYPE, `FN_AND, randomBit(), randomBit(), "AND");
			issue(`OP_RTYPE, `FN_SLT, randomBit(), randomBit(), "SLT");
			issue(`OP_ADDI, 6'd0, randomBit(), randomBit(), "ADDI");
			issue(`OP_ADDIU, 6'd0, randomBit(), randomBit(), "ADDIU");
			issue(`OP_SLTI, 6'd0, randomBit(), randomBit(), "SLTI");
		end

		issue(`OP_LW, 6'd0, 1'b0, 1'b0, "LW");
		issue(`OP_LW, 6'd0, 1'b1, 1'b1, "LW");
		issue(`OP_SW, 6'd0, 1'b0, 1'b1, "SW");

		issue(`OP_BEQ, 6'd0, 1'b0, 1'b0, "BEQ");
		issue(`OP_BEQ, 6'd0, 1'b0, 1'b1, "BEQ");
		issue(`OP_BNE, 6'd0, 1'b0, 1'b0, "BNE");
		issue(`OP_BNE, 6'd0, 1'b0, 1'b1, "BNE");
		issue(`OP_J, 6'd0, 1'b0, 1'b0, "J");
		issue(`OP_RTYPE, `FN_JR, 1'b0, 1'b0, "JR");

		issue(`OP_RTYPE, `FN_ADD, 1'b1, 1'b0, "ADD");
		issue(`OP_RTYPE, `FN_SUB, 1'b1, 1'b0, "SUB");
		issue(`OP_ADDI, 6'd0, 1'b1, 1'b0, "ADDI");
		issue(`OP_ADDIU, 6'd0, 1'b1, 1'b0, "ADDIU");

		issueUnkept(8);

		if (!timedOut) begin
			waitFetch("end of run");   // lets the last instruction close
		end
		@(posedge clock);
		assertFailed = controlUnit_inst.controlUnit_assert_inst.anyFailed;
		$display("%0d tests, %0d failed, %0d checks, %0d mismatches, timeout %0b, assertions %0b",
			testCount, failedTests, checkCount, errorCount, timedOut, assertFailed);
		if (errorCount == 0 && !timedOut && !assertFailed) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- tests/controlUnit_assert.sv
// control word invariants, checked on the falling edge while rstN is high; needs --assert to run
module controlUnit_assert import controlPkg::*; (
	input logic      clock,
	input logic      rstN,
	input ctrlWord_t ctrl
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [2:0] idleCycles;          // cycles since the last irWrite
	logic       sawIrMem = 1'b0;
	logic       sawEpc = 1'b0;
	logic       sawRegMem = 1'b0;
	logic       sawLateFetch = 1'b0;
	logic       anyFailed;           // read by the testbench at the end

	assign anyFailed = sawIrMem | sawEpc | sawRegMem | sawLateFetch;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			idleCycles <= '0;
		end else if (ctrl.irWrite) begin
			idleCycles <= '0;
		end else if (idleCycles != 3'd7) begin
			idleCycles <= idleCycles + 3'd1;   // saturates
		end
	end

	irMemExclusive: assert property (@(negedge clock) disable iff (!rstN)
		!(ctrl.irWrite && ctrl.memWrite))
		else begin
			$error("irWrite and memWrite high in the same cycle");
			sawIrMem = 1'b1;
		end

	epcRedirects: assert property (@(negedge clock) disable iff (!rstN)
		ctrl.epcWrite |-> (ctrl.pcWrite && ctrl.pcSource == pcExceptionVector))
		else begin
			$error("epcWrite without a write of the exception vector to pc");
			sawEpc = 1'b1;
		end

	regMemExclusive: assert property (@(negedge clock) disable iff (!rstN)
		!(ctrl.regWrite && ctrl.memWrite))
		else begin
			$error("regWrite and memWrite high in the same cycle");
			sawRegMem = 1'b1;
		end

	// longest instruction is lw, so the next fetch is at most 5 cycles away
	fetchWithinFive: assert property (@(negedge clock) disable iff (!rstN)
		!(idleCycles >= 3'd4 && !ctrl.irWrite))
		else begin
			$error("no irWrite within 5 cycles of the previous one");
			sawLateFetch = 1'b1;
		end

endmodule

bind controlUnit controlUnit_assert controlUnit_assert_inst (
	.clock (clock),
	.rstN  (rstN),
	.ctrl  (ctrl)
);

//--- logic/controlUnit.sv
// multicycle MIPS subset control; ctrl is combinational from state, so the datapath registers it
module controlUnit import controlPkg::*; (
	input  logic      clock,
	input  logic      rstN,
	input  opcode_t   opcode,
	input  funct_t    funct,
	input  logic      overflow,   // ALU signed overflow
	input  logic      equal,      // ALU operands equal
	output ctrlWord_t ctrl
);

	instrClass_t instrClass;
	cycleState_t state;

	instrDecoder instrDecoder_inst (
		.opcode     (opcode),
		.funct      (funct),
		.instrClass (instrClass)
	);

	cycleSequencer cycleSequencer_inst (
		.clock      (clock),
		.rstN       (rstN),
		.instrClass (instrClass),
		.state      (state)
	);

	controlWordGen controlWordGen_inst (
		.rstN       (rstN),
		.state      (state),
		.instrClass (instrClass),
		.overflow   (overflow),
		.equal      (equal),
		.ctrl       (ctrl)
	);

endmodule

//--- logic/controlWordGen.sv
// overflow and equal are sampled combinationally in the cycle that uses them; all writes are low in reset
module controlWordGen import controlPkg::*; (
	input  logic        rstN,
	input  cycleState_t state,
	input  instrClass_t instrClass,
	input  logic        overflow,
	input  logic        equal,
	output ctrlWord_t   ctrl
);

	ctrlWord_t word;
	logic      trapsOverflow;  // add, sub, addi raise the exception
	logic      isRType;

	always_comb begin
		trapsOverflow = (instrClass == classAdd) || (instrClass == classSub)
			|| (instrClass == classAddi);
		isRType = (instrClass == classAdd) || (instrClass == classSub)
			|| (instrClass == classAnd);
	end

	always_comb begin
		word = '{
			pcWrite: 1'b0,
			pcSource: pcAluResult,
			memAddrSel: addrPc,
			memWrite: 1'b0,
			irWrite: 1'b0,
			mdrWrite: 1'b0,
			abLoad: 1'b0,
			aluSrcA: srcPc,
			aluSrcB: srcRegB,
			aluOp: aluPass,
			aluOutWrite: 1'b0,
			regWrite: 1'b0,
			regDst: dstRd,
			regData: dataAluOut,
			epcWrite: 1'b0
		};
		case (state)
			stFetch: begin
				word.irWrite = 1'b1;
				word.aluSrcB = srcFour;
				word.aluOp = aluAdd;
				word.pcWrite = 1'b1;   // pc + 4
			end
			stDecode: begin
				word.abLoad = 1'b1;
				word.aluSrcB = srcBranchOffset;   // branch target, ready in aluOut
				word.aluOp = aluAdd;
				word.aluOutWrite = 1'b1;
			end
			stExecute: begin
				case (instrClass)
					classAdd, classSub, classAnd: begin
						word.aluSrcA = srcRegA;
						word.aluOutWrite = 1'b1;
						if (instrClass == classAdd) begin
							word.aluOp = aluAdd;
						end else if (instrClass == classSub) begin
							word.aluOp = aluSub;
						end else begin
							word.aluOp = aluAnd;
						end
					end
					classAddi, classAddiu, classLw, classSw: begin
						word.aluSrcA = srcRegA;
						word.aluSrcB = srcSignImm;   // address or immediate sum
						word.aluOp = aluAdd;
						word.aluOutWrite = 1'b1;
					end
					classSlt, classSlti: begin
						// less-than flag goes to the register file this cycle
						word.aluSrcA = srcRegA;
						word.aluOp = aluSlt;
						word.regWrite = 1'b1;
						word.regData = dataLessThan;
						if (instrClass == classSlti) begin
							word.aluSrcB = srcSignImm;
							word.regDst = dstRt;
						end
					end
					classBeq, classBne: begin
						word.aluSrcA = srcRegA;
						word.aluOp = aluSub;
						word.pcSource = pcAluOut;
						word.pcWrite = (instrClass == classBeq) ? equal : !equal;
					end
					classJ: begin
						word.pcSource = pcJumpTarget;
						word.pcWrite = 1'b1;
					end
					classJr: begin
						word.pcSource = pcRegA;
						word.pcWrite = 1'b1;
					end
					default: ;   // no-op, nothing written
				endcase
			end
			stMemory: begin
				word.memAddrSel = addrAluOut;
				word.mdrWrite = (instrClass == classLw);
				word.memWrite = (instrClass == classSw);
			end
			stWriteback: begin
				if (trapsOverflow && overflow) begin
					word.epcWrite = 1'b1;
					word.pcSource = pcExceptionVector;
					word.pcWrite = 1'b1;
				end else begin
					word.regWrite = 1'b1;
					word.regDst = isRType ? dstRd : dstRt;
					word.regData = (instrClass == classLw) ? dataMdr : dataAluOut;
				end
			end
			default: ;
		endcase

		if (!rstN) begin
			word.pcWrite = 1'b0;
			word.memWrite = 1'b0;
			word.irWrite = 1'b0;
			word.mdrWrite = 1'b0;
			word.abLoad = 1'b0;
			word.aluOutWrite = 1'b0;
			word.regWrite = 1'b0;
			word.epcWrite = 1'b0;
		end
	end

	assign ctrl = word;

endmodule

//--- logic/cycleSequencer.sv
// one instruction at a time; instruction length is 3 to 5 cycles depending on its class
module cycleSequencer import controlPkg::*; (
	input  logic        clock,
	input  logic        rstN,
	input  instrClass_t instrClass,
	output cycleState_t state
);

	cycleState_t nextState;
	logic        needsMemory;     // lw and sw
	logic        needsWriteback;  // result comes back through aluOut or mdr

	always_comb begin
		needsMemory = (instrClass == classLw) || (instrClass == classSw);
	end

	always_comb begin
		case (instrClass)
			classAdd,
			classSub,
			classAnd,
			classAddi,
			classAddiu,
			classLw: needsWriteback = 1'b1;
			default: needsWriteback = 1'b0;   // slt, slti write straight from the ALU
		endcase
	end

	always_comb begin
		nextState = stFetch;
		case (state)
			stFetch: begin
				nextState = stDecode;
			end
			stDecode: begin
				nextState = stExecute;   // class is valid from here on
			end
			stExecute: begin
				if (needsMemory) begin
					nextState = stMemory;
				end else if (needsWriteback) begin
					nextState = stWriteback;
				end else begin
					nextState = stFetch;
				end
			end
			stMemory: begin
				// only the load carries on to write the register file
				if (needsWriteback) begin
					nextState = stWriteback;
				end else begin
					nextState = stFetch;
				end
			end
			stWriteback: begin
				nextState = stFetch;
			end
			default: begin
				nextState = stFetch;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= stFetch;
		end else begin
			state <= nextState;
		end
	end

endmodule

//--- logic/instrDecoder.sv
// purely combinational; opcode and funct must come from the instruction register, not the memory bus
`include "control_defs.svh"

module instrDecoder import controlPkg::*; (
	input  opcode_t     opcode,
	input  funct_t      funct,
	output instrClass_t instrClass
);

	instrClass_t rClass;   // class of an R-type word, from funct

	always_comb begin
		case (funct)
			`FN_ADD: rClass = classAdd;
			`FN_SUB: rClass = classSub;
			`FN_AND: rClass = classAnd;
			`FN_SLT: rClass = classSlt;
			`FN_JR: rClass = classJr;
			default: rClass = classNone;   // shifts, mult, div etc
		endcase
	end

	always_comb begin
		case (opcode)
			`OP_RTYPE: instrClass = rClass;
			`OP_ADDI: instrClass = classAddi;
			`OP_ADDIU: instrClass = classAddiu;
			`OP_SLTI: instrClass = classSlti;
			`OP_LW: instrClass = classLw;
			`OP_SW: instrClass = classSw;
			`OP_BEQ: instrClass = classBeq;
			`OP_BNE: instrClass = classBne;
			`OP_J: instrClass = classJ;
			default: instrClass = classNone;   // runs as a no-op
		endcase
	end

endmodule

//--- logic/controlPkg.sv
// control word types for the multicycle unit; selector encodings must match the datapath muxes
package controlPkg;

`include "control_defs.svh"

	typedef logic [`OPCODE_WIDTH-1:0] opcode_t;
	typedef logic [`FUNCT_WIDTH-1:0] funct_t;

	// decoded instruction, one entry per kept operation
	typedef enum logic [3:0] {
		classAdd,
		classSub,
		classAnd,
		classSlt,
		classAddi,
		classAddiu,
		classSlti,
		classLw,
		classSw,
		classBeq,
		classBne,
		classJ,
		classJr,
		classNone   // anything not kept
	} instrClass_t;

	typedef enum logic [2:0] {
		stFetch,
		stDecode,
		stExecute,
		stMemory,
		stWriteback
	} cycleState_t;

	typedef enum logic [2:0] {aluPass, aluAdd, aluSub, aluAnd, aluSlt} aluOp_t;

	typedef enum logic {srcPc, srcRegA} srcA_t;

	typedef enum logic [1:0] {
		srcRegB,
		srcFour,
		srcSignImm,
		srcBranchOffset   // sign extended and shifted left by 2
	} srcB_t;

	typedef enum logic [2:0] {
		pcAluResult,       // pc + 4 straight from the ALU
		pcAluOut,          // branch target latched in decode
		pcJumpTarget,
		pcRegA,
		pcExceptionVector
	} pcSource_t;

	typedef enum logic {addrPc, addrAluOut} addrSel_t;
	typedef enum logic {dstRd, dstRt} regDst_t;
	typedef enum logic [1:0] {dataAluOut, dataMdr, dataLessThan} regData_t;

	typedef struct packed {
		logic      pcWrite;
		pcSource_t pcSource;
		addrSel_t  memAddrSel;
		logic      memWrite;
		logic      irWrite;
		logic      mdrWrite;
		logic      abLoad;
		srcA_t     aluSrcA;
		srcB_t     aluSrcB;
		aluOp_t    aluOp;
		logic      aluOutWrite;
		logic      regWrite;
		regDst_t   regDst;
		regData_t  regData;
		logic      epcWrite;
	} ctrlWord_t;

endpackage

//--- include/control_defs.svh
// MIPS encodings of the kept opcodes and function codes only; any other value decodes as a no-op
`ifndef CONTROL_DEFS_SVH
`define CONTROL_DEFS_SVH

// instruction field widths
`define OPCODE_WIDTH 6
`define FUNCT_WIDTH  6

// primary opcodes, instr[31:26]
`define OP_RTYPE 6'd0   // funct selects the operation
`define OP_J     6'd2
`define OP_BEQ   6'd4
`define OP_BNE   6'd5
`define OP_ADDI  6'd8   // traps on overflow
`define OP_ADDIU 6'd9   // never traps
`define OP_SLTI  6'd10
`define OP_LW    6'd35
`define OP_SW    6'd43

// function codes, instr[5:0], valid only with OP_RTYPE
`define FN_JR  6'd8
`define FN_ADD 6'd32    // traps on overflow
`define FN_SUB 6'd34    // traps on overflow
`define FN_AND 6'd36
`define FN_SLT 6'd42

`endif
